// ==== common/rvPkg.sv ====
// Shared widths, instruction encodings and pipeline types, imported by every rvCore file
package rvPkg;

	// ==============================
	// Widths and constants
	// ==============================
	localparam int Xlen     = 32;
	localparam int RegAddrW = 5;
	localparam int NumRegs  = 32;

	localparam logic [Xlen-1:0] ResetPc = '0;
	localparam logic [Xlen-1:0] NopInst = 32'h0000_0013;  // addi x0, x0, 0

	// ==============================
	// Encodings
	// ==============================
	// Major opcode, instruction bits 6:2
	typedef enum logic [4:0] {
		OpLoad   = 5'b00000,
		OpImm    = 5'b00100,
		OpStore  = 5'b01000,
		OpReg    = 5'b01100,
		OpBranch = 5'b11000,
		OpJalr   = 5'b11001,
		OpJal    = 5'b11011
	} opcodeT;

	// Bit 3 is the funct7 alternate bit, bits 2:0 follow funct3
	typedef enum logic [3:0] {
		AluAdd = 4'b0000,
		AluSll = 4'b0001,
		AluSlt = 4'b0010,
		AluXor = 4'b0100,
		AluSrl = 4'b0101,
		AluOr  = 4'b0110,
		AluAnd = 4'b0111,
		AluSub = 4'b1000,
		AluSra = 4'b1101
	} aluOpT;

	// EX operand source
	typedef enum logic [1:0] {
		FwdReg = 2'b00,
		FwdMem = 2'b01,
		FwdWb  = 2'b10
	} fwdSelT;

	// ==============================
	// Pipeline payloads
	// ==============================
	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrcImm;   // Operand B from imm
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  regWrite;
		logic  isJump;      // Write back the link address
	} ctrlT;

	typedef struct packed {
		ctrlT                ctrl;
		logic [Xlen-1:0]     rs1Data;
		logic [Xlen-1:0]     rs2Data;
		logic [Xlen-1:0]     imm;
		logic [RegAddrW-1:0] rs1;
		logic [RegAddrW-1:0] rs2;
		logic [RegAddrW-1:0] rd;
		logic [Xlen-1:0]     pcPlus4;
	} idExT;

	// One register write port, as seen from MEM or WB
	typedef struct packed {
		logic                regWrite;
		logic [RegAddrW-1:0] rd;
		logic [Xlen-1:0]     data;
	} wbT;

endpackage

// ==== exec/rvAlu.sv ====
// Combinational integer ALU for the EX stage
`timescale 1ns/1ps

module rvAlu import rvPkg::*; (
	input  logic [Xlen-1:0] a,
	input  logic [Xlen-1:0] b,
	input  aluOpT           op,
	output logic [Xlen-1:0] y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			AluAdd:  y = a + b;
			AluSub:  y = a - b;
			AluSll:  y = a << shamt;
			AluSlt:  y = {{(Xlen-1){1'b0}}, $signed(a) < $signed(b)};  // Signed compare
			AluXor:  y = a ^ b;
			AluSrl:  y = a >> shamt;
			AluSra:  y = $signed(a) >>> shamt;
			AluOr:   y = a | b;
			AluAnd:  y = a & b;
			default: y = '0;
		endcase
	end

endmodule

// ==== exec/rvExecute.sv ====
// ID/EX, EX/MEM and MEM/WB stages with operand forwarding, data port and write-back select
`timescale 1ns/1ps

module rvExecute import rvPkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                flushId,
	input  idExT                idEx,
	input  fwdSelT              fwdA,
	input  fwdSelT              fwdB,
	output logic [RegAddrW-1:0] exRd,
	output logic [RegAddrW-1:0] exRs1,
	output logic [RegAddrW-1:0] exRs2,
	output logic                exRegWrite,
	output logic                exMemRead,
	output logic                memIsLoad,
	output logic                dmemRead,
	output logic                dmemWrite,
	output logic [Xlen-1:0]     dmemAddr,
	output logic [Xlen-1:0]     dmemWData,
	input  logic [Xlen-1:0]     dmemRData,
	output wbT                  memWb,
	output wbT                  wbWb
);

	typedef struct packed {
		ctrlT                ctrl;
		logic [Xlen-1:0]     aluY;
		logic [Xlen-1:0]     storeData;
		logic [Xlen-1:0]     pcPlus4;
		logic [RegAddrW-1:0] rd;
	} exMemT;

	typedef struct packed {
		ctrlT                ctrl;
		logic [Xlen-1:0]     aluY;
		logic [Xlen-1:0]     loadData;
		logic [Xlen-1:0]     pcPlus4;
		logic [RegAddrW-1:0] rd;
	} memWbT;

	idExT            idExQ;
	exMemT           exMemQ;
	memWbT           memWbQ;
	logic [Xlen-1:0] opA;
	logic [Xlen-1:0] opB;
	logic [Xlen-1:0] aluY;

	// ==============================
	// EX
	// ==============================
	always_comb begin
		case (fwdA)
			FwdMem:  opA = memWb.data;
			FwdWb:   opA = wbWb.data;
			default: opA = idExQ.rs1Data;
		endcase
		case (fwdB)
			FwdMem:  opB = memWb.data;
			FwdWb:   opB = wbWb.data;
			default: opB = idExQ.rs2Data;
		endcase
	end

	rvAlu alu0 (.a(opA), .b(idExQ.ctrl.aluSrcImm ? idExQ.imm : opB), .op(idExQ.ctrl.aluOp),
		.y(aluY));

	assign exRd       = idExQ.rd;
	assign exRs1      = idExQ.rs1;
	assign exRs2      = idExQ.rs2;
	assign exRegWrite = idExQ.ctrl.regWrite;
	assign exMemRead  = idExQ.ctrl.memRead;

	// ==============================
	// MEM and WB
	// ==============================
	assign memIsLoad = exMemQ.ctrl.memRead;
	assign dmemRead  = exMemQ.ctrl.memRead;
	assign dmemWrite = exMemQ.ctrl.memWrite;
	assign dmemAddr  = exMemQ.aluY;
	assign dmemWData = exMemQ.storeData;

	// Load data not ready here, loads are covered by stalls
	assign memWb = '{regWrite: exMemQ.ctrl.regWrite, rd: exMemQ.rd,
		data: exMemQ.ctrl.isJump ? exMemQ.pcPlus4 : exMemQ.aluY};

	assign wbWb = '{regWrite: memWbQ.ctrl.regWrite, rd: memWbQ.rd,
		data: memWbQ.ctrl.isJump ? memWbQ.pcPlus4 :
			memWbQ.ctrl.memToReg ? memWbQ.loadData : memWbQ.aluY};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idExQ.ctrl  <= '0;
			exMemQ.ctrl <= '0;
			memWbQ.ctrl <= '0;
		end else begin
			idExQ <= idEx;
			if (stall || flushId) begin
				idExQ.ctrl <= '0;   // Bubble
			end
			exMemQ <= '{ctrl: idExQ.ctrl, aluY: aluY, storeData: opB,
				pcPlus4: idExQ.pcPlus4, rd: idExQ.rd};
			memWbQ <= '{ctrl: exMemQ.ctrl, aluY: exMemQ.aluY, loadData: dmemRData,
				pcPlus4: exMemQ.pcPlus4, rd: exMemQ.rd};
		end
	end

endmodule

// ==== fetch/rvFetch.sv ====
// PC and IF/ID register, resolves branches and jumps in ID with MEM and WB forwarding
`timescale 1ns/1ps

module rvFetch import rvPkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  logic [Xlen-1:0] imemData,
	output logic [Xlen-1:0] imemAddr,
	input  logic [Xlen-1:0] rs1Data,
	input  logic [Xlen-1:0] rs2Data,
	input  logic [Xlen-1:0] imm,
	input  ctrlT            ctrl,
	input  logic            isBranch,
	input  logic            isBranchNe,
	input  logic            isJalr,
	input  wbT              memWb,
	input  wbT              wbWb,
	output logic [Xlen-1:0] idInst,
	output logic [Xlen-1:0] idPcPlus4,
	output logic            flushId
);

	logic [Xlen-1:0] pc;
	logic [Xlen-1:0] idPc;
	logic            idValid;   // Low when IF/ID holds a flushed slot
	logic [Xlen-1:0] opA;
	logic [Xlen-1:0] opB;
	logic [Xlen-1:0] jalrSum;
	logic [Xlen-1:0] target;
	logic            taken;
	logic            redirect;

	// Newest producer wins
	function automatic logic [Xlen-1:0] fwdId(input logic [RegAddrW-1:0] rs,
			input logic [Xlen-1:0] regData, input wbT memW, input wbT wbW);
		if (memW.regWrite && memW.rd != '0 && memW.rd == rs)
			return memW.data;
		if (wbW.regWrite && wbW.rd != '0 && wbW.rd == rs)
			return wbW.data;
		return regData;
	endfunction

	assign opA = fwdId(idInst[19:15], rs1Data, memWb, wbWb);
	assign opB = fwdId(idInst[24:20], rs2Data, memWb, wbWb);

	assign jalrSum  = opA + imm;
	assign target   = isJalr ? {jalrSum[Xlen-1:1], 1'b0} : idPc + imm;
	assign taken    = ctrl.isJump | (isBranch & ((opA == opB) ^ isBranchNe));
	assign redirect = taken & ~stall;   // Operands not final while stalled

	assign imemAddr  = pc;
	assign idPcPlus4 = idPc + 32'd4;
	assign flushId   = ~idValid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= ResetPc;
			idInst  <= NopInst;
			idValid <= 1'b0;
		end else if (!stall) begin
			pc      <= redirect ? target : pc + 32'd4;
			idPc    <= pc;
			idInst  <= redirect ? NopInst : imemData;  // Kill wrong-path fetch
			idValid <= ~redirect;
		end
	end

endmodule

// ==== rtl/rvDecoder.sv ====
// ID-stage decode of the RV32I subset into control, immediate and ALU operation
`timescale 1ns/1ps

module rvDecoder import rvPkg::*; (
	input  logic [Xlen-1:0] inst,
	output ctrlT            ctrl,
	output logic [Xlen-1:0] imm,
	output logic            isBranch,
	output logic            isBranchNe,
	output logic            isJalr,
	output logic            isJal
);

	opcodeT          opcode;
	logic [2:0]      funct3;
	logic            altBit;
	aluOpT           selAluOp;
	logic [Xlen-1:0] immI;
	logic [Xlen-1:0] immS;
	logic [Xlen-1:0] immB;
	logic [Xlen-1:0] immJ;
	logic [Xlen-1:0] immShamt;

	assign opcode = opcodeT'(inst[6:2]);
	assign funct3 = inst[14:12];

	// funct7 bit 5 counts only for R-type and right shifts
	assign altBit = inst[30] & ((opcode == OpReg) | (funct3 == 3'b101));

	assign immI     = {{20{inst[31]}}, inst[31:20]};
	assign immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immJ     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign immShamt = {{(Xlen-5){1'b0}}, inst[24:20]};

	always_comb begin
		case ({altBit, funct3})
			4'b0000: selAluOp = AluAdd;
			4'b1000: selAluOp = AluSub;
			4'b0001: selAluOp = AluSll;
			4'b0010: selAluOp = AluSlt;
			4'b0100: selAluOp = AluXor;
			4'b0101: selAluOp = AluSrl;
			4'b1101: selAluOp = AluSra;
			4'b0110: selAluOp = AluOr;
			4'b0111: selAluOp = AluAnd;
			default: selAluOp = AluAdd;
		endcase
	end

	always_comb begin
		ctrl       = '0;   // Bubble unless recognized
		imm        = '0;
		isBranch   = 1'b0;
		isBranchNe = 1'b0;
		isJalr     = 1'b0;
		isJal      = 1'b0;
		case (opcode)
			OpReg: begin
				ctrl.aluOp    = selAluOp;
				ctrl.regWrite = 1'b1;
			end
			OpImm: begin
				ctrl.aluOp     = selAluOp;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
				imm = (funct3[1:0] == 2'b01) ? immShamt : immI;   // slli, srli, srai
			end
			OpLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead   = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.regWrite  = 1'b1;
				imm = immI;
			end
			OpStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
				imm = immS;
			end
			OpBranch: begin
				isBranch   = (funct3[2:1] == 2'b00);   // beq and bne only
				isBranchNe = funct3[0];
				imm = immB;
			end
			OpJal: begin
				isJal         = 1'b1;
				ctrl.isJump   = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = immJ;
			end
			OpJalr: begin
				isJalr        = 1'b1;
				ctrl.isJump   = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = immI;
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/rvRegFile.sv ====
// Integer register file, two read ports with write-through from the WB port
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [RegAddrW-1:0] rs1,
	input  logic [RegAddrW-1:0] rs2,
	output logic [Xlen-1:0]     rs1Data,
	output logic [Xlen-1:0]     rs2Data,
	input  wbT                  wb
);

	logic [Xlen-1:0] regs [NumRegs];
	logic            wrEn;

	assign wrEn = wb.regWrite && (wb.rd != '0);   // x0 stays zero

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Same-cycle write is visible to ID
	assign rs1Data = (wrEn && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2Data = (wrEn && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

// ==== rtl/rvHazardUnit.sv ====
// ID-stage stall detection and EX-stage operand forwarding selects
`timescale 1ns/1ps

module rvHazardUnit import rvPkg::*; (
	input  logic [RegAddrW-1:0] rs1,
	input  logic [RegAddrW-1:0] rs2,
	input  logic                isBranch,
	input  logic                isJalr,
	input  logic                isJal,
	input  logic [RegAddrW-1:0] exRd,
	input  logic                exRegWrite,
	input  logic                exMemRead,
	input  wbT                  memWb,
	input  wbT                  wbWb,
	input  logic                memIsLoad,
	input  logic [RegAddrW-1:0] exMemRs1,   // Sources of the instruction in EX
	input  logic [RegAddrW-1:0] exMemRs2,
	output logic                stall,
	output fwdSelT              fwdA,
	output fwdSelT              fwdB
);

	logic loadUse;
	logic srcRs1;
	logic srcRs2;
	logic branchWait;

	function automatic logic hit(input logic [RegAddrW-1:0] rd, input logic [RegAddrW-1:0] rs);
		return (rd != '0) && (rd == rs);
	endfunction

	function automatic fwdSelT pick(input logic [RegAddrW-1:0] rs, input wbT memW, input wbT wbW);
		if (memW.regWrite && hit(memW.rd, rs))
			return FwdMem;
		if (wbW.regWrite && hit(wbW.rd, rs))
			return FwdWb;
		return FwdReg;
	endfunction

	assign loadUse = exMemRead & (hit(exRd, rs1) | hit(exRd, rs2));

	// ID compare needs a value that is not ready yet
	assign srcRs1 = (exRegWrite & hit(exRd, rs1)) | (memIsLoad & hit(memWb.rd, rs1));
	assign srcRs2 = (exRegWrite & hit(exRd, rs2)) | (memIsLoad & hit(memWb.rd, rs2));
	assign branchWait = (isBranch & (srcRs1 | srcRs2)) | (isJalr & srcRs1);

	assign stall = ~isJal & (loadUse | branchWait);  // jal reads no registers

	assign fwdA = pick(exMemRs1, memWb, wbWb);
	assign fwdB = pick(exMemRs2, memWb, wbWb);

endmodule

// ==== rtl/rvCore.sv ====
// Five-stage RV32I subset core, connects fetch, decode, register file, hazard unit and execute
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	output logic [Xlen-1:0] imemAddr,
	input  logic [Xlen-1:0] imemData,
	output logic            dmemRead,
	output logic            dmemWrite,
	output logic [Xlen-1:0] dmemAddr,
	output logic [Xlen-1:0] dmemWData,
	input  logic [Xlen-1:0] dmemRData
);

	// ID stage
	logic [Xlen-1:0] idInst;
	logic [Xlen-1:0] idPcPlus4;
	logic [Xlen-1:0] imm;
	logic [Xlen-1:0] rs1Data;
	logic [Xlen-1:0] rs2Data;
	ctrlT            ctrl;
	logic            isBranch;
	logic            isBranchNe;
	logic            isJalr;
	logic            isJal;
	idExT            idEx;

	// Hazards and forwarding
	logic                stall;
	logic                flushId;
	fwdSelT              fwdA;
	fwdSelT              fwdB;
	logic [RegAddrW-1:0] exRd;
	logic [RegAddrW-1:0] exRs1;
	logic [RegAddrW-1:0] exRs2;
	logic                exRegWrite;
	logic                exMemRead;
	logic                memIsLoad;
	wbT                  memWb;
	wbT                  wbWb;

	// Field order follows idExT
	assign idEx = {ctrl, rs1Data, rs2Data, imm, idInst[19:15], idInst[24:20], idInst[11:7],
		idPcPlus4};

	rvFetch fetch0 (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.imemData(imemData), .imemAddr(imemAddr),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .ctrl(ctrl),
		.isBranch(isBranch), .isBranchNe(isBranchNe), .isJalr(isJalr),
		.memWb(memWb), .wbWb(wbWb),
		.idInst(idInst), .idPcPlus4(idPcPlus4), .flushId(flushId)
	);

	rvDecoder dec0 (
		.inst(idInst), .ctrl(ctrl), .imm(imm),
		.isBranch(isBranch), .isBranchNe(isBranchNe), .isJalr(isJalr), .isJal(isJal)
	);

	rvRegFile regs0 (
		.clk(clk), .rst_n(rst_n),
		.rs1(idInst[19:15]), .rs2(idInst[24:20]),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .wb(wbWb)
	);

	rvHazardUnit hazard0 (
		.rs1(idInst[19:15]), .rs2(idInst[24:20]),
		.isBranch(isBranch), .isJalr(isJalr), .isJal(isJal),
		.exRd(exRd), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.memWb(memWb), .wbWb(wbWb), .memIsLoad(memIsLoad),
		.exMemRs1(exRs1), .exMemRs2(exRs2),
		.stall(stall), .fwdA(fwdA), .fwdB(fwdB)
	);

	rvExecute exec0 (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flushId(flushId), .idEx(idEx),
		.fwdA(fwdA), .fwdB(fwdB),
		.exRd(exRd), .exRs1(exRs1), .exRs2(exRs2),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead), .memIsLoad(memIsLoad),
		.dmemRead(dmemRead), .dmemWrite(dmemWrite), .dmemAddr(dmemAddr),
		.dmemWData(dmemWData), .dmemRData(dmemRData),
		.memWb(memWb), .wbWb(wbWb)
	);

endmodule

// ==== verif/rvCore_props.sv ====
// Memory port assertions for rvCore, attached to every rvCore instance through bind
`timescale 1ns/1ps

module rvCoreProps import rvPkg::*; (
	input logic            clk,
	input logic            rst_n,
	input logic [Xlen-1:0] imemAddr,
	input logic            dmemRead,
	input logic            dmemWrite,
	input logic [Xlen-1:0] dmemAddr
);

	// One data access per cycle
	strobeExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemRead && dmemWrite))
		else $error("dmemRead and dmemWrite are high in the same cycle");

	// Sync reset clears the pipeline by the next edge
	quietInReset: assert property (@(posedge clk) !rst_n |=> !dmemRead && !dmemWrite)
		else $error("Data strobe high after a reset edge");

	fetchAligned: assert property (@(posedge clk) disable iff (!rst_n)
		imemAddr[1:0] == 2'b00)
		else $error("imemAddr is not word aligned");

	dataAligned: assert property (@(posedge clk) disable iff (!rst_n)
		(dmemRead || dmemWrite) |-> dmemAddr[1:0] == 2'b00)
		else $error("dmemAddr is not word aligned during an access");

endmodule

bind rvCore rvCoreProps props0 (.*);

// ==== verif/rvCoreTb.sv ====
// Testbench for rvCore, runs random programs and checks every store against an ISA model
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

	localparam int BodyLen     = 40;
	localparam int DumpRegs    = 15;
	localparam int ProgLen     = BodyLen + DumpRegs + 1;
	localparam int DumpBase    = 1024;
	localparam int ResetCycles = 5;
	localparam int TailCycles  = 4;
	localparam int NumTests    = 6;

	logic            clk;
	logic            rst_n;
	logic [Xlen-1:0] imemAddr;
	logic [Xlen-1:0] imemData;
	logic            dmemRead;
	logic            dmemWrite;
	logic [Xlen-1:0] dmemAddr;
	logic [Xlen-1:0] dmemWData;
	logic [Xlen-1:0] dmemRData;

	logic [Xlen-1:0] imem [128];
	logic [Xlen-1:0] dmem [512];
	logic [Xlen-1:0] refMem [512];
	logic [Xlen-1:0] refRegs [NumRegs];
	logic [Xlen-1:0] expAddr [$];   // Store order from the model
	logic [Xlen-1:0] expData [$];
	int              expLoads;
	int              loadsSeen;
	int              errors;
	int              storesSeen;
	int              testsRun;
	int              testsFailed;

	rvCore dut0 (.clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
		.dmemRead(dmemRead), .dmemWrite(dmemWrite), .dmemAddr(dmemAddr),
		.dmemWData(dmemWData), .dmemRData(dmemRData));

	assign imemData  = imem[imemAddr[8:2]];   // Both memories read combinationally
	assign dmemRData = dmem[dmemAddr[10:2]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Long enough for every program even with a stall on each instruction
	initial begin
		repeat (NumTests * (10 * ProgLen + ResetCycles + TailCycles)) @(posedge clk);
		$display("Watchdog expired before the expected stores appeared");
		$display("** FAIL **");
		$finish;
	end

	// ==============================
	// Instruction encoding
	// ==============================
	function automatic logic [31:0] encR(input logic [31:0] f7, input logic [31:0] rs2,
			input logic [31:0] rs1, input logic [31:0] f3, input logic [31:0] rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpReg, 2'b11};
	endfunction

	function automatic logic [31:0] encI(input opcodeT op, input logic [31:0] imm,
			input logic [31:0] rs1, input logic [31:0] f3, input logic [31:0] rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op, 2'b11};
	endfunction

	function automatic logic [31:0] encS(input logic [31:0] imm, input logic [31:0] rs2,
			input logic [31:0] rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OpStore, 2'b11};
	endfunction

	function automatic logic [31:0] encB(input logic [31:0] imm, input logic [31:0] rs2,
			input logic [31:0] rs1, input logic [31:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			OpBranch, 2'b11};
	endfunction

	function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [31:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OpJal, 2'b11};
	endfunction

	// Forward targets only, so every program reaches the final self jump
	task automatic genProgram(input int pLoad, input int pStore, input int pBranch,
			input int pJump, input int pDep, input int pX0);
		int               i;
		int               r;
		int               rd;
		int               rs1;
		int               rs2;
		int               f3;
		int               t;
		int               lastRd;
		logic [31:0]      imm;
		logic [BodyLen:0] targeted;   // Slots some branch or jump lands on
		for (int k = 0; k < 128; k++)
			imem[k] = NopInst;
		i        = 0;
		lastRd   = 1;
		targeted = '0;
		while (i < BodyLen) begin
			r   = $urandom_range(99);
			rd  = ($urandom_range(99) < pX0) ? 0 : $urandom_range(15, 1);
			rs1 = ($urandom_range(99) < pDep) ? lastRd : $urandom_range(15);
			rs2 = $urandom_range(15);
			f3  = $urandom_range(7);
			t   = i + $urandom_range(4, 2);
			if (t > BodyLen)
				t = BodyLen;
			if (f3 == 3)
				f3 = 0;   // No sltu in the subset
			if (r < pLoad) begin
				imem[i] = encI(OpLoad, 4 * $urandom_range(255), 0, 2, rd);
			end else if (r < pLoad + pStore) begin
				imem[i] = encS(4 * $urandom_range(255), rs1, 0);   // Data may be fresh
			end else if (r < pLoad + pStore + pBranch) begin
				if ($urandom_range(2) == 0)
					rs2 = rs1;   // Equal operands
				imem[i] = encB(4 * (t - i), rs2, rs1, $urandom_range(1));
				targeted[t] = 1'b1;
			end else if (r < pLoad + pStore + pBranch + pJump) begin
				// The jalr must not be a target, or its base write would be skipped
				if (i + 1 < BodyLen && !targeted[i + 1] && $urandom_range(1) == 1) begin
					rs2     = $urandom_range(15, 1);   // jalr base, written just before
					imem[i] = encI(OpImm, 4 * t - 4, 0, 0, rs2);
					i++;
					imem[i] = encI(OpJalr, 4, rs2, 0, rd);
				end else begin
					imem[i] = encJ(4 * (t - i), rd);
				end
				targeted[t] = 1'b1;
			end else if ($urandom_range(1) == 1) begin
				imem[i] = encR((f3 == 0 || f3 == 5) ? 32 * $urandom_range(1) : 0,
					rs2, rs1, f3, rd);
			end else begin
				if (f3 == 1)
					imm = $urandom_range(31);
				else if (f3 == 5)
					imm = 1024 * $urandom_range(1) + $urandom_range(31);   // srli or srai
				else
					imm = $urandom_range(4095);
				imem[i] = encI(OpImm, imm, rs1, f3, rd);
			end
			lastRd = rd;
			i++;
		end
		for (int k = 1; k <= DumpRegs; k++)
			imem[BodyLen + k - 1] = encS(DumpBase + 4 * k, k, 0);   // Final register state
		imem[ProgLen - 1] = encJ(0, 0);
	endtask

	// ==============================
	// ISA model
	// ==============================
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic        wr;
		int          steps;
		for (int k = 0; k < NumRegs; k++)
			refRegs[k] = '0;
		pc    = ResetPc;
		steps = 0;
		while (pc != 4 * (ProgLen - 1) && steps < 1000) begin
			inst   = imem[pc[8:2]];
			a      = refRegs[inst[19:15]];
			b      = refRegs[inst[24:20]];
			immI   = {{20{inst[31]}}, inst[31:20]};
			immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			immB   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			immJ   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			res    = '0;
			wr     = 1'b0;
			nextPc = pc + 4;
			case (opcodeT'(inst[6:2]))
				OpReg: begin
					res = aluRef(inst[14:12], inst[30], a, b);
					wr  = 1'b1;
				end
				OpImm: begin
					res = aluRef(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, immI);
					wr  = 1'b1;
				end
				OpLoad: begin
					addr = a + immI;
					res  = refMem[addr[10:2]];
					wr   = 1'b1;
					expLoads++;
				end
				OpStore: begin
					addr = a + immS;
					expAddr.push_back(addr);
					expData.push_back(b);
					refMem[addr[10:2]] = b;
				end
				OpBranch: begin
					if ((a == b) != inst[12])
						nextPc = pc + immB;
				end
				OpJal: begin
					res    = pc + 4;
					wr     = 1'b1;
					nextPc = pc + immJ;
				end
				OpJalr: begin
					res    = pc + 4;
					wr     = 1'b1;
					nextPc = (a + immI) & ~32'd1;
				end
				default: ;
			endcase
			if (wr && inst[11:7] != 5'd0)
				refRegs[inst[11:7]] = res;
			pc = nextPc;
			steps++;
		end
	endtask

	// ==============================
	// Checking and test flow
	// ==============================
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %0s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic sampleDataPort();
		if (dmemRead)
			loadsSeen++;
		if (dmemWrite) begin
			if (expAddr.size() == 0) begin
				$display("Store to address %h that the program never makes", dmemAddr);
				errors++;
			end else begin
				check("dmemAddr", dmemAddr, expAddr.pop_front());
				check("dmemWData", dmemWData, expData.pop_front());
			end
			dmem[dmemAddr[10:2]] = dmemWData;
			storesSeen++;
		end
	endtask

	task automatic runTest(input string name, input int pLoad, input int pStore,
			input int pBranch, input int pJump, input int pDep, input int pX0);
		int          errsBefore;
		int          expCount;
		logic [31:0] salt;
		errsBefore = errors;
		rst_n      = 1'b0;
		genProgram(pLoad, pStore, pBranch, pJump, pDep, pX0);
		salt = $urandom;
		for (int k = 0; k < 512; k++) begin
			dmem[k]   = (k + 1) * 32'h9E37_79B1 ^ salt;
			refMem[k] = dmem[k];
		end
		expAddr.delete();
		expData.delete();
		storesSeen = 0;
		loadsSeen  = 0;
		expLoads   = 0;
		runModel();
		expCount = expAddr.size();
		repeat (ResetCycles) @(negedge clk);
		rst_n = 1'b1;
		while (storesSeen < expCount) begin
			@(negedge clk);
			sampleDataPort();
		end
		repeat (TailCycles) begin   // Catch stray stores after the last one
			@(negedge clk);
			sampleDataPort();
		end
		check("dmemRead count", loadsSeen, expLoads);
		testsRun++;
		if (errors == errsBefore) begin
			$display("Test %0s passed with %0d stores", name, expCount);
		end else begin
			testsFailed++;
			$display("Test %0s failed with %0d errors", name, errors - errsBefore);
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		errors      = 0;
		storesSeen  = 0;
		loadsSeen   = 0;
		expLoads    = 0;
		testsRun    = 0;
		testsFailed = 0;
		void'($urandom(31));
		for (int k = 0; k < 128; k++)
			imem[k] = NopInst;
		for (int k = 0; k < 512; k++)
			dmem[k] = '0;
		runTest("aluChains", 0, 15, 0, 0, 10, 0);
		runTest("forwarding", 0, 15, 0, 0, 85, 0);
		runTest("loadUse", 30, 20, 0, 0, 70, 0);
		runTest("branches", 10, 15, 35, 0, 50, 0);
		runTest("jumps", 0, 15, 10, 35, 50, 0);
		runTest("x0Writes", 10, 20, 5, 5, 30, 40);
		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== rvCore.f ====
common/rvPkg.sv
exec/rvAlu.sv
exec/rvExecute.sv
fetch/rvFetch.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvHazardUnit.sv
rtl/rvCore.sv
verif/rvCore_props.sv
verif/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run rvCoreTb with Verilator, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o rvCoreSim || exit 1
./obj_dir/rvCoreSim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
echo "Simulation passed"
